//--- verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  localparam logic [4:0]        SRAM_BASE_TAG = 5'b10000;
  localparam int                SRAM_WORDS    = 1024;
  localparam logic [ADDR_W-1:0] CLINT_BASE    = 32'hA000_0048;
  localparam logic [ADDR_W-1:0] UART_BASE     = 32'hA000_03F8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  localparam int UART_DIV = 4; // Clocks per serial bit.

  // The counter is bumped through count and read back through word.
  typedef union packed {
    logic [63:0]             count;
    logic [1:0][DATA_W-1:0]  word; // word[0] sits at 0x48, word[1] at 0x4C.
  } mtime_t;

endpackage

`default_nettype wire

//--- verilog/axi_r_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axi_r_if;
  import soc_pkg::*;

  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport slave (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

endinterface

`default_nettype wire

//--- verilog/axi_w_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axi_w_if;
  import soc_pkg::*;

  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );

endinterface

`default_nettype wire

//--- verilog/axi_xbar.sv
`timescale 1ns/100ps
`default_nettype none

module axi_xbar (
  input logic     clk,
  input logic     rstn,
  axi_r_if.slave  cpu_r,
  axi_r_if.master sram_r,
  axi_r_if.master clint_r,
  axi_w_if.slave  cpu_w,
  axi_w_if.master sram_w,
  axi_w_if.master uart_w
);
  import soc_pkg::*;

  logic r_own_sram, r_own_clint, r_own_err, r_busy;
  logic rsel_sram, rsel_clint;
  logic ar_fire, r_fire;
  logic w_own_sram, w_own_uart, w_own_err, w_busy;
  logic wsel_sram, wsel_uart;
  logic both_valid;
  logic w_fire, b_fire;

  // Read path.
  assign rsel_sram  = (cpu_r.araddr[31:27] == SRAM_BASE_TAG);
  assign rsel_clint = (cpu_r.araddr[31:3] == CLINT_BASE[31:3]);
  assign r_busy     = r_own_sram | r_own_clint | r_own_err;

  assign sram_r.araddr   = cpu_r.araddr;
  assign clint_r.araddr  = cpu_r.araddr;
  assign sram_r.arvalid  = ~r_busy & cpu_r.arvalid & rsel_sram;
  assign clint_r.arvalid = ~r_busy & cpu_r.arvalid & rsel_clint;

  assign cpu_r.arready = ~r_busy & (rsel_sram  ? sram_r.arready  :
                                    rsel_clint ? clint_r.arready :
                                    1'b1); // Unmapped reads are taken here.

  assign sram_r.rready  = r_own_sram & cpu_r.rready;
  assign clint_r.rready = r_own_clint & cpu_r.rready;

  assign cpu_r.rvalid = (r_own_sram & sram_r.rvalid) | (r_own_clint & clint_r.rvalid) |
                        r_own_err;
  assign cpu_r.rdata  = r_own_sram  ? sram_r.rdata  :
                        r_own_clint ? clint_r.rdata : '0;
  assign cpu_r.rresp  = r_own_sram  ? sram_r.rresp  :
                        r_own_clint ? clint_r.rresp : RESP_DECERR;

  assign ar_fire = cpu_r.arvalid & cpu_r.arready;
  assign r_fire  = cpu_r.rvalid & cpu_r.rready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_own_sram  <= 1'b0;
      r_own_clint <= 1'b0;
      r_own_err   <= 1'b0;
    end else if (ar_fire) begin
      r_own_sram  <= rsel_sram;
      r_own_clint <= rsel_clint;
      r_own_err   <= ~rsel_sram & ~rsel_clint; // DECERR goes out on the next cycle.
    end else if (r_fire) begin
      r_own_sram  <= 1'b0;
      r_own_clint <= 1'b0;
      r_own_err   <= 1'b0;
    end
  end

  // Write path.
  assign wsel_sram  = (cpu_w.awaddr[31:27] == SRAM_BASE_TAG);
  assign wsel_uart  = (cpu_w.awaddr == UART_BASE);
  assign w_busy     = w_own_sram | w_own_uart | w_own_err;
  assign both_valid = cpu_w.awvalid & cpu_w.wvalid;

  assign sram_w.awaddr  = cpu_w.awaddr;
  assign sram_w.wdata   = cpu_w.wdata;
  assign sram_w.wstrb   = cpu_w.wstrb;
  assign sram_w.awvalid = ~w_busy & cpu_w.awvalid & wsel_sram;
  assign sram_w.wvalid  = ~w_busy & cpu_w.wvalid & wsel_sram;
  assign uart_w.awaddr  = cpu_w.awaddr;
  assign uart_w.wdata   = cpu_w.wdata;
  assign uart_w.wstrb   = cpu_w.wstrb;
  assign uart_w.awvalid = ~w_busy & cpu_w.awvalid & wsel_uart;
  assign uart_w.wvalid  = ~w_busy & cpu_w.wvalid & wsel_uart;

  assign cpu_w.awready = ~w_busy & (wsel_sram ? sram_w.awready :
                                    wsel_uart ? uart_w.awready : both_valid);
  assign cpu_w.wready  = ~w_busy & (wsel_sram ? sram_w.wready :
                                    wsel_uart ? uart_w.wready : both_valid);

  assign sram_w.bready = w_own_sram & cpu_w.bready;
  assign uart_w.bready = w_own_uart & cpu_w.bready;

  assign cpu_w.bvalid = (w_own_sram & sram_w.bvalid) | (w_own_uart & uart_w.bvalid) |
                        w_own_err;
  assign cpu_w.bresp  = w_own_sram ? sram_w.bresp :
                        w_own_uart ? uart_w.bresp : RESP_DECERR;

  assign w_fire = both_valid & cpu_w.awready & cpu_w.wready;
  assign b_fire = cpu_w.bvalid & cpu_w.bready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      w_own_sram <= 1'b0;
      w_own_uart <= 1'b0;
      w_own_err  <= 1'b0;
    end else if (w_fire) begin
      w_own_sram <= wsel_sram;
      w_own_uart <= wsel_uart;
      w_own_err  <= ~wsel_sram & ~wsel_uart; // The CLINT is read-only, so it lands here too.
    end else if (b_fire) begin
      w_own_sram <= 1'b0;
      w_own_uart <= 1'b0;
      w_own_err  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axi_sram (
  input logic    clk,
  input logic    rstn,
  axi_r_if.slave rd,
  axi_w_if.slave wr
);
  import soc_pkg::*;

  logic [DATA_W-1:0] mem [SRAM_WORDS];
  logic [$clog2(SRAM_WORDS)-1:0] rd_idx;
  logic [$clog2(SRAM_WORDS)-1:0] wr_idx;
  logic [DATA_W-1:0] rdata_q;
  logic rvalid_q;
  logic bvalid_q;
  logic ar_fire;
  logic w_fire;

  // The window is far larger than the array, so upper bits alias.
  assign rd_idx = rd.araddr[$clog2(SRAM_WORDS)+1:2];
  assign wr_idx = wr.awaddr[$clog2(SRAM_WORDS)+1:2];

  assign rd.arready = ~rvalid_q;
  assign rd.rvalid  = rvalid_q;
  assign rd.rdata   = rdata_q;
  assign rd.rresp   = RESP_OKAY;

  assign wr.awready = ~bvalid_q & wr.awvalid & wr.wvalid; // Address and data go in together.
  assign wr.wready  = ~bvalid_q & wr.awvalid & wr.wvalid;
  assign wr.bvalid  = bvalid_q;
  assign wr.bresp   = RESP_OKAY;

  assign ar_fire = rd.arvalid & rd.arready;
  assign w_fire  = wr.awvalid & wr.awready & wr.wvalid & wr.wready;

  always_ff @(posedge clk) begin
    if (w_fire) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr.wstrb[i]) begin
          mem[wr_idx][8*i +: 8] <= wr.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        rvalid_q <= 1'b1;
      end else if (rd.rready) begin
        rvalid_q <= 1'b0;
      end
      if (w_fire) begin
        bvalid_q <= 1'b1;
      end else if (wr.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_clint.sv
`timescale 1ns/100ps
`default_nettype none

module axi_clint (
  input logic    clk,
  input logic    rstn,
  axi_r_if.slave rd
);
  import soc_pkg::*;

  mtime_t mtime;
  logic [DATA_W-1:0] rdata_q;
  logic rvalid_q;
  logic ar_fire;

  assign rd.arready = ~rvalid_q;
  assign rd.rvalid  = rvalid_q;
  assign rd.rdata   = rdata_q;
  assign rd.rresp   = RESP_OKAY;

  assign ar_fire = rd.arvalid & rd.arready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      mtime.count <= 64'd0;
    end else begin
      mtime.count <= mtime.count + 64'd1;
    end
  end

  // The word is frozen at the handshake so a stalled response stays stable.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= mtime.word[rd.araddr[2]];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (rd.rready) begin
      rvalid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module axi_uart_tx (
  input  logic   clk,
  input  logic   rstn,
  axi_w_if.slave wr,
  output logic   txd,
  output logic   tx_busy
);
  import soc_pkg::*;

  logic [9:0] frame_q;
  logic [3:0] bits_left;
  logic [$clog2(UART_DIV)-1:0] div_cnt;
  logic busy_q;
  logic bvalid_q;
  logic idle;
  logic accept;

  assign idle      = ~busy_q & ~bvalid_q;
  assign wr.awready = idle & wr.awvalid & wr.wvalid;
  assign wr.wready  = idle & wr.awvalid & wr.wvalid;
  assign wr.bvalid  = bvalid_q;
  assign wr.bresp   = RESP_OKAY;

  assign accept  = wr.awvalid & wr.awready & wr.wvalid & wr.wready;
  assign txd     = frame_q[0];
  assign tx_busy = busy_q;

  always_ff @(posedge clk) begin
    if (rstn) begin
      frame_q   <= '1; // Line idles high.
      bits_left <= 4'd0;
      div_cnt   <= '0;
      busy_q    <= 1'b0;
    end else if (accept) begin
      frame_q   <= {1'b1, wr.wdata[7:0], 1'b0}; // Stop, data, start.
      bits_left <= 4'd10;
      div_cnt   <= '0;
      busy_q    <= 1'b1;
    end else if (busy_q) begin
      if (div_cnt == UART_DIV - 1) begin
        div_cnt   <= '0;
        frame_q   <= {1'b1, frame_q[9:1]};
        bits_left <= bits_left - 4'd1;
        if (bits_left == 4'd1) begin
          busy_q <= 1'b0;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      bvalid_q <= 1'b0;
    end else if (accept) begin
      bvalid_q <= 1'b1;
    end else if (wr.bready) begin
      bvalid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/soc_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_mem_top (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic [soc_pkg::ADDR_W-1:0]   araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [soc_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready,
  input  logic [soc_pkg::ADDR_W-1:0]   awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [soc_pkg::DATA_W-1:0]   wdata,
  input  logic [soc_pkg::STRB_W-1:0]   wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  output logic                         txd,
  output logic                         tx_busy
);

  axi_r_if cpu_r ();
  axi_w_if cpu_w ();
  axi_r_if sram_r ();
  axi_w_if sram_w ();
  axi_r_if clint_r ();
  axi_w_if uart_w ();

  assign cpu_r.araddr  = araddr;
  assign cpu_r.arvalid = arvalid;
  assign cpu_r.rready  = rready;
  assign arready       = cpu_r.arready;
  assign rdata         = cpu_r.rdata;
  assign rresp         = cpu_r.rresp;
  assign rvalid        = cpu_r.rvalid;

  assign cpu_w.awaddr  = awaddr;
  assign cpu_w.awvalid = awvalid;
  assign cpu_w.wdata   = wdata;
  assign cpu_w.wstrb   = wstrb;
  assign cpu_w.wvalid  = wvalid;
  assign cpu_w.bready  = bready;
  assign awready       = cpu_w.awready;
  assign wready        = cpu_w.wready;
  assign bresp         = cpu_w.bresp;
  assign bvalid        = cpu_w.bvalid;

  axi_xbar u_axi_xbar (
    .clk     (clk),
    .rstn    (rstn),
    .cpu_r   (cpu_r),
    .sram_r  (sram_r),
    .clint_r (clint_r),
    .cpu_w   (cpu_w),
    .sram_w  (sram_w),
    .uart_w  (uart_w)
  );

  axi_sram u_axi_sram (
    .clk  (clk),
    .rstn (rstn),
    .rd   (sram_r),
    .wr   (sram_w)
  );

  axi_clint u_axi_clint (
    .clk  (clk),
    .rstn (rstn),
    .rd   (clint_r)
  );

  axi_uart_tx u_axi_uart_tx (
    .clk     (clk),
    .rstn    (rstn),
    .wr      (uart_w),
    .txd     (txd),
    .tx_busy (tx_busy)
  );

endmodule

`default_nettype wire

//--- tb/tb_soc_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc_mem_top;
  import soc_pkg::*;

  typedef enum {WAIT_AR, WAIT_AW, WAIT_R, WAIT_B, WAIT_START} wait_kind_t;

  logic              clk, rstn;
  logic [ADDR_W-1:0] araddr, awaddr;
  logic [DATA_W-1:0] rdata, wdata;
  logic [STRB_W-1:0] wstrb;
  logic [1:0]        rresp, bresp;
  logic              arvalid, arready, rvalid, rready;
  logic              awvalid, awready, wvalid, wready, bvalid, bready;
  logic              txd, tx_busy;
  logic              accept_busy; // tx_busy as seen in the cycle of the last write accept.
  integer            seed;
  int                errors;

  soc_mem_top u_soc_mem_top (.*);

  always #10 clk = ~clk;

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic flag_set(input wait_kind_t kind);
    case (kind)
      WAIT_AR: return arready;
      WAIT_AW: return awready & wready;
      WAIT_R:  return rvalid;
      WAIT_B:  return bvalid;
      default: return ~txd; // A start bit pulls the line low.
    endcase
  endfunction

  task automatic abort_run(input string what);
    $display("Timed out waiting for %s at %0t", what, $time);
    $display("Errors: %0d", errors);
    $display("Simulation failed");
    $finish;
  endtask

  // Samples at the falling edge, half a cycle away from any DUT update.
  task automatic wait_flag(input wait_kind_t kind, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!flag_set(kind)) begin
      n++;
      if (n > 200) begin
        abort_run(what);
      end
      @(negedge clk);
    end
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got resp %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_byte(input logic [7:0] got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got %b, expected %b", $time, msg, got, exp);
    end
  endtask

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] word;
    word = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    wait_flag(WAIT_AW, "awready and wready");
    accept_busy = tx_busy;
    step_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    wait_flag(WAIT_B, "bvalid");
    resp = bresp;
    step_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    wait_flag(WAIT_AR, "arready");
    step_cycle();
    arvalid = 1'b0;
    wait_flag(WAIT_R, "rvalid");
    data = rdata;
    resp = rresp;
    step_cycle();
    rready = 1'b0;
  endtask

  task automatic uart_capture(output logic [7:0] data);
    logic [9:0] bits;
    wait_flag(WAIT_START, "UART start bit");
    repeat (UART_DIV / 2) @(negedge clk); // First low sample is half a cycle into the bit.
    for (int i = 0; i < 10; i++) begin
      bits[i] = txd;
      if (i < 9) begin
        repeat (UART_DIV) @(negedge clk);
      end
    end
    check_bit(bits[0], 1'b0, "UART start bit");
    check_bit(bits[9], 1'b1, "UART stop bit");
    data = bits[8:1];
  endtask

  task automatic test_clint();
    logic [DATA_W-1:0] lo_first, lo_second, hi;
    logic [1:0] resp;
    axi_read(CLINT_BASE + 32'd4, hi, resp);
    check_data(hi, '0, "mtime high word");
    check_resp(resp, RESP_OKAY, "mtime high response");
    axi_read(CLINT_BASE, lo_first, resp);
    check_resp(resp, RESP_OKAY, "mtime low response");
    axi_read(CLINT_BASE, lo_second, resp);
    check_bit(lo_second > lo_first, 1'b1, "mtime low word increases");
  endtask

  task automatic test_sram();
    logic [DATA_W-1:0] words [4];
    logic [DATA_W-1:0] got, patch, merged;
    logic [1:0] resp;
    for (int i = 0; i < 4; i++) begin
      words[i] = $random(seed);
      axi_write(32'h8000_0040 + 8 * i, words[i], 4'hF, resp);
      check_resp(resp, RESP_OKAY, "SRAM write");
    end
    for (int i = 0; i < 4; i++) begin
      axi_read(32'h8000_0040 + 8 * i, got, resp);
      check_data(got, words[i], "SRAM read back");
      check_resp(resp, RESP_OKAY, "SRAM read");
    end
    patch  = $random(seed);
    merged = merge_bytes(words[1], patch, 4'b0110);
    axi_write(32'h8000_0048, patch, 4'b0110, resp);
    axi_read(32'h8000_0048, got, resp);
    check_data(got, merged, "SRAM partial strobe merge");
    axi_write(32'h8000_0000, ~words[3], 4'hF, resp);
    axi_read(32'h8000_1000, got, resp); // Index wraps at bit 12.
    check_data(got, ~words[3], "SRAM alias of word 0");
  endtask

  task automatic test_uart();
    logic [7:0] sent [2];
    logic [7:0] got [2];
    logic [1:0] resp;
    sent[0] = 8'($random(seed));
    sent[1] = 8'($random(seed));
    fork
      begin
        axi_write(UART_BASE, {24'd0, sent[0]}, 4'h1, resp);
        check_resp(resp, RESP_OKAY, "UART first write");
        check_bit(tx_busy, 1'b1, "UART busy during frame");
        axi_write(UART_BASE, {24'd0, sent[1]}, 4'h1, resp);
        check_resp(resp, RESP_OKAY, "UART second write");
        check_bit(accept_busy, 1'b0, "UART idle at second accept");
      end
      begin
        uart_capture(got[0]);
        uart_capture(got[1]);
      end
    join
    step_cycle();
    check_byte(got[0], sent[0], "UART first byte");
    check_byte(got[1], sent[1], "UART second byte");
  endtask

  task automatic test_decode_error();
    logic [DATA_W-1:0] got, word;
    logic [1:0] resp;
    axi_read(32'h0000_0000, got, resp);
    check_resp(resp, RESP_DECERR, "read of address 0");
    check_data(got, '0, "read data of address 0");
    axi_read(32'hA000_0050, got, resp);
    check_resp(resp, RESP_DECERR, "read past mtime");
    check_data(got, '0, "read data past mtime");
    axi_write(CLINT_BASE, 32'h1234_5678, 4'hF, resp);
    check_resp(resp, RESP_DECERR, "write to read-only CLINT");
    word = $random(seed);
    axi_write(32'h8000_0200, word, 4'hF, resp);
    axi_read(32'h8000_0200, got, resp);
    check_data(got, word, "SRAM read after DECERR");
    check_resp(resp, RESP_OKAY, "SRAM response after DECERR");
  endtask

  task automatic test_read_backpressure();
    logic [DATA_W-1:0] word_a, word_b, got, held;
    logic [1:0] resp, held_resp;
    word_a = $random(seed);
    word_b = $random(seed);
    axi_write(32'h8000_0300, word_a, 4'hF, resp);
    axi_write(32'h8000_0304, word_b, 4'hF, resp);
    araddr  = 32'h8000_0300;
    arvalid = 1'b1;
    rready  = 1'b0;
    wait_flag(WAIT_AR, "arready");
    step_cycle();
    araddr = 32'h8000_0304; // Second request waits behind the stalled one.
    wait_flag(WAIT_R, "rvalid");
    held      = rdata;
    held_resp = rresp;
    check_data(held, word_a, "stalled read data");
    check_resp(held_resp, RESP_OKAY, "stalled read response");
    repeat (4) begin
      @(negedge clk);
      check_bit(rvalid, 1'b1, "rvalid under back-pressure");
      check_data(rdata, held, "rdata under back-pressure");
      check_resp(rresp, held_resp, "rresp under back-pressure");
      check_bit(arready, 1'b0, "arready while read outstanding");
    end
    step_cycle();
    rready = 1'b1;
    wait_flag(WAIT_R, "rvalid");
    step_cycle();
    axi_read(32'h8000_0304, got, resp);
    check_data(got, word_b, "read after back-pressure");
    check_resp(resp, RESP_OKAY, "response after read back-pressure");
  endtask

  task automatic test_write_backpressure();
    logic [DATA_W-1:0] word_a, word_b, got;
    logic [1:0] resp, held_resp;
    word_a  = $random(seed);
    word_b  = $random(seed);
    awaddr  = 32'h8000_0380;
    wdata   = word_a;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    wait_flag(WAIT_AW, "awready and wready");
    step_cycle();
    awaddr = 32'h8000_0384;
    wdata  = word_b;
    wait_flag(WAIT_B, "bvalid");
    held_resp = bresp;
    check_resp(held_resp, RESP_OKAY, "stalled write response");
    repeat (4) begin
      @(negedge clk);
      check_bit(bvalid, 1'b1, "bvalid under back-pressure");
      check_resp(bresp, held_resp, "bresp under back-pressure");
      check_bit(awready | wready, 1'b0, "write ready while write outstanding");
    end
    step_cycle();
    bready = 1'b1;
    wait_flag(WAIT_B, "bvalid");
    step_cycle();
    axi_write(32'h8000_0384, word_b, 4'hF, resp);
    check_resp(resp, RESP_OKAY, "write after back-pressure");
    axi_read(32'h8000_0380, got, resp);
    check_data(got, word_a, "stalled write data");
    axi_read(32'h8000_0384, got, resp);
    check_data(got, word_b, "write data after back-pressure");
  endtask

  initial begin
    clk         = 1'b0;
    rstn        = 1'b1;
    araddr      = '0;
    awaddr      = '0;
    wdata       = '0;
    wstrb       = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    awvalid     = 1'b0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    accept_busy = 1'b0;
    seed        = 67;
    errors      = 0;
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b0;
    test_clint(); // First, while mtime is still small.
    test_sram();
    test_uart();
    test_decode_error();
    test_read_backpressure();
    test_write_backpressure();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/soc_pkg.sv
verilog/axi_r_if.sv
verilog/axi_w_if.sv
verilog/axi_xbar.sv
verilog/axi_sram.sv
verilog/axi_clint.sv
verilog/axi_uart_tx.sv
verilog/soc_mem_top.sv
tb/tb_soc_mem_top.sv
